/* boot_sequencer.sv */
// ------------------------------
// boot sequencer
// steps through zero, copy, verify and run
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module boot_sequencer (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_calib_done,
    input  wire                        i_zero_done,
    input  wire                        i_copy_done,
    input  wire                        i_verify_done,
    output mem_maint_pkg::boot_state_e o_state,
    output logic                       o_boot_done
);

    mem_maint_pkg::boot_state_e state_q;
    mem_maint_pkg::boot_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_maint_pkg::ST_IDLE: begin
                if (i_calib_done)
                    state_d = mem_maint_pkg::ST_ZERO;
            end
            mem_maint_pkg::ST_ZERO: begin
                if (i_zero_done)
                    state_d = mem_maint_pkg::ST_COPY;
            end
            mem_maint_pkg::ST_COPY: begin
                if (i_copy_done)
                    state_d = mem_maint_pkg::ST_VERIFY;
            end
            mem_maint_pkg::ST_VERIFY: begin
                if (i_verify_done)
                    state_d = mem_maint_pkg::ST_RUN;
            end
            mem_maint_pkg::ST_RUN: state_d = mem_maint_pkg::ST_RUN;  // until reset
            default: state_d = mem_maint_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= mem_maint_pkg::ST_IDLE;
            o_boot_done <= 1'b0;
        end else begin
            state_q     <= state_d;
            o_boot_done <= (state_d == mem_maint_pkg::ST_RUN);
        end
    end

    assign o_state = state_q;

    // phases only ever move forward between resets
    a_state_forward: assert property (@(posedge clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> state_q >= $past(state_q));

endmodule

`default_nettype wire

/* files.f */
mem_maint_pkg.sv
zero_fill.sv
image_copier.sv
readback_checker.sv
boot_sequencer.sv
mem_port_mux.sv
mem_maint.sv
tb_clock_gen.sv
tb_sdram_model.sv
tb_mem_maint.sv

/* image_copier.sv */
// ------------------------------
// image copier
// writes loader words to memory and sums a checksum
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module image_copier (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_start,
    input  wire                     i_load_valid,
    input  wire mem_maint_pkg::word_t i_load_data,
    output logic                    o_load_take,
    input  wire                     i_mem_busy,
    output mem_maint_pkg::mem_req_t o_req,
    output mem_maint_pkg::word_t    o_checksum,
    output logic                    o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_BUSY,
        S_WAIT_DONE
    } cp_state_e;

    cp_state_e            state_q;
    mem_maint_pkg::addr_t addr_q;
    mem_maint_pkg::addr_t addr_next;
    mem_maint_pkg::word_t data_q;
    logic                 wr_q;
    logic                 take_word;

    assign addr_next = mem_maint_pkg::next_word_addr(addr_q);

    // a word is only taken while the port is idle
    assign take_word = (state_q == S_IDLE) && i_start && !o_done &&
                       i_load_valid && !i_mem_busy;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= S_IDLE;
            addr_q      <= '0;
            wr_q        <= 1'b0;
            o_load_take <= 1'b0;
            o_checksum  <= '0;
            o_done      <= 1'b0;
        end else begin
            o_load_take <= take_word;   // single cycle pulse
            case (state_q)
                S_IDLE: begin
                    if (take_word) begin
                        wr_q       <= 1'b1;
                        o_checksum <= o_checksum + i_load_data;
                        state_q    <= S_WAIT_BUSY;
                    end
                end
                S_WAIT_BUSY: begin
                    if (i_mem_busy) begin
                        wr_q    <= 1'b0;
                        state_q <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: begin
                    if (!i_mem_busy) begin  // write finished
                        addr_q  <= addr_next;
                        state_q <= S_IDLE;
                        if (addr_next == mem_maint_pkg::addr_t'(mem_maint_pkg::IMAGE_BYTES))
                            o_done <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // word holding register
    always_ff @(posedge clk) begin
        if (take_word)
            data_q <= i_load_data;
    end

    always_comb begin
        o_req       = '0;
        o_req.wr_en = wr_q;
        o_req.addr  = addr_q;
        o_req.wdata = data_q;
        o_req.ctrl  = mem_maint_pkg::FULL_MASK;
    end

    // loader handshake must never overlap a memory transaction
    a_take_not_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_load_take |-> !i_mem_busy);

endmodule

`default_nettype wire

/* mem_maint.sv */
// ------------------------------
// memory maintenance top
// boot engines and cpu port in front of the sdram controller
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_maint (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_calib_done,
    input  wire                       i_load_valid,
    input  wire mem_maint_pkg::word_t i_load_data,
    output logic                      o_load_take,
    input  wire mem_maint_pkg::mem_req_t i_cpu_req,
    output mem_maint_pkg::word_t      o_cpu_rdata,
    output logic                      o_cpu_busy,
    output mem_maint_pkg::mem_req_t   o_mem_req,
    input  wire                       i_mem_busy,
    input  wire mem_maint_pkg::word_t i_mem_rdata,
    output logic                      o_boot_done,
    output logic                      o_checksum_match
);

    mem_maint_pkg::boot_state_e w_state;
    mem_maint_pkg::mem_req_t    w_zero_req;
    mem_maint_pkg::mem_req_t    w_copy_req;
    mem_maint_pkg::mem_req_t    w_verify_req;
    mem_maint_pkg::word_t       w_checksum;
    logic                       w_zero_done;
    logic                       w_copy_done;
    logic                       w_verify_done;
    logic                       w_zero_start;
    logic                       w_copy_start;
    logic                       w_verify_start;

    // one start level per phase
    assign w_zero_start   = (w_state == mem_maint_pkg::ST_ZERO);
    assign w_copy_start   = (w_state == mem_maint_pkg::ST_COPY);
    assign w_verify_start = (w_state == mem_maint_pkg::ST_VERIFY);

    assign o_cpu_rdata = i_mem_rdata;   // read data straight from the controller

    boot_sequencer u_boot_sequencer (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_calib_done   (i_calib_done),
        .i_zero_done    (w_zero_done),
        .i_copy_done    (w_copy_done),
        .i_verify_done  (w_verify_done),
        .o_state        (w_state),
        .o_boot_done    (o_boot_done)
    );

    zero_fill u_zero_fill (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_start    (w_zero_start),
        .i_mem_busy (i_mem_busy),
        .o_req      (w_zero_req),
        .o_done     (w_zero_done)
    );

    image_copier u_image_copier (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (w_copy_start),
        .i_load_valid (i_load_valid),
        .i_load_data  (i_load_data),
        .o_load_take  (o_load_take),
        .i_mem_busy   (i_mem_busy),
        .o_req        (w_copy_req),
        .o_checksum   (w_checksum),
        .o_done       (w_copy_done)
    );

    readback_checker u_readback_checker (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_start        (w_verify_start),
        .i_mem_busy     (i_mem_busy),
        .i_mem_rdata    (i_mem_rdata),
        .i_expected_sum (w_checksum),
        .o_req          (w_verify_req),
        .o_match        (o_checksum_match),
        .o_done         (w_verify_done)
    );

    mem_port_mux u_mem_port_mux (
        .i_state      (w_state),
        .i_zero_req   (w_zero_req),
        .i_copy_req   (w_copy_req),
        .i_verify_req (w_verify_req),
        .i_cpu_req    (i_cpu_req),
        .i_mem_busy   (i_mem_busy),
        .o_mem_req    (o_mem_req),
        .o_cpu_busy   (o_cpu_busy)
    );

    // the image must lie inside the zeroed region
    if (mem_maint_pkg::IMAGE_BYTES > mem_maint_pkg::ZERO_BYTES) begin : g_size_check
        $error("image region larger than zero region");
    end

endmodule

`default_nettype wire

/* mem_maint_pkg.sv */
// ------------------------------
// memory maintenance package
// sizes, boot phases, memory request and address helpers
// ------------------------------
`default_nettype none

package mem_maint_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // cpu address window of 64 MiB
    localparam addr_t ADDR_MASK = 32'h03ff_ffff;

    // region sizes in bytes
    localparam int unsigned ZERO_BYTES  = 128;
    localparam int unsigned IMAGE_BYTES = 64;    // image sits at address 0

    localparam logic [3:0] FULL_MASK = 4'b1111;   // all four byte lanes

    // boot phases in the order they run
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,   // waiting for calibration
        ST_ZERO   = 3'd1,
        ST_COPY   = 3'd2,
        ST_VERIFY = 3'd3,
        ST_RUN    = 3'd4    // cpu owns the port
    } boot_state_e;

    // one request of the strobe-and-busy protocol
    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        addr_t      addr;
        word_t      wdata;
        logic [3:0] ctrl;   // byte mask
    } mem_req_t;

    // cpu address folded into the memory range
    function automatic addr_t mask_addr(input addr_t a);
        return a & ADDR_MASK;
    endfunction

    // next word address for the boot engines
    function automatic addr_t next_word_addr(input addr_t a);
        return a + addr_t'(4);
    endfunction

endpackage

`default_nettype wire

/* mem_port_mux.sv */
// ------------------------------
// memory port mux
// picks the active requester, holds the cpu off during boot
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_port_mux (
    input  wire mem_maint_pkg::boot_state_e i_state,
    input  wire mem_maint_pkg::mem_req_t    i_zero_req,
    input  wire mem_maint_pkg::mem_req_t    i_copy_req,
    input  wire mem_maint_pkg::mem_req_t    i_verify_req,
    input  wire mem_maint_pkg::mem_req_t    i_cpu_req,
    input  wire                             i_mem_busy,
    output mem_maint_pkg::mem_req_t         o_mem_req,
    output logic                            o_cpu_busy
);

    always_comb begin
        o_mem_req  = '0;    // nothing on the port while idle
        o_cpu_busy = 1'b1;
        case (i_state)
            mem_maint_pkg::ST_ZERO:   o_mem_req = i_zero_req;
            mem_maint_pkg::ST_COPY:   o_mem_req = i_copy_req;
            mem_maint_pkg::ST_VERIFY: o_mem_req = i_verify_req;
            mem_maint_pkg::ST_RUN: begin
                o_mem_req      = i_cpu_req;     // cpu byte mask passes through
                o_mem_req.addr = mem_maint_pkg::mask_addr(i_cpu_req.addr);
                o_cpu_busy     = i_mem_busy;
            end
            default: o_mem_req = '0;
        endcase
    end

endmodule

`default_nettype wire

/* readback_checker.sv */
// ------------------------------
// readback checker
// reads the image back and compares its sum
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module readback_checker (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_start,
    input  wire                       i_mem_busy,
    input  wire mem_maint_pkg::word_t i_mem_rdata,
    input  wire mem_maint_pkg::word_t i_expected_sum,
    output mem_maint_pkg::mem_req_t   o_req,
    output logic                      o_match,
    output logic                      o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_BUSY,
        S_WAIT_DATA     // read in flight
    } rb_state_e;

    rb_state_e            state_q;
    mem_maint_pkg::addr_t addr_q;
    mem_maint_pkg::addr_t addr_next;
    mem_maint_pkg::word_t sum_q;
    mem_maint_pkg::word_t sum_next;
    logic                 rd_q;
    logic                 last_word;

    assign addr_next = mem_maint_pkg::next_word_addr(addr_q);
    assign sum_next  = sum_q + i_mem_rdata;
    assign last_word = (addr_next == mem_maint_pkg::addr_t'(mem_maint_pkg::IMAGE_BYTES));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            addr_q  <= '0;
            sum_q   <= '0;
            rd_q    <= 1'b0;
            o_match <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (i_start && !o_done && !i_mem_busy) begin
                        rd_q    <= 1'b1;
                        state_q <= S_WAIT_BUSY;
                    end
                end
                S_WAIT_BUSY: begin
                    if (i_mem_busy) begin
                        rd_q    <= 1'b0;
                        state_q <= S_WAIT_DATA;
                    end
                end
                S_WAIT_DATA: begin
                    // rdata is valid on the first cycle busy is low again
                    if (!i_mem_busy) begin
                        sum_q   <= sum_next;
                        addr_q  <= addr_next;
                        state_q <= S_IDLE;
                        if (last_word) begin
                            o_match <= (sum_next == i_expected_sum);
                            o_done  <= 1'b1;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        o_req       = '0;
        o_req.rd_en = rd_q;
        o_req.addr  = addr_q;
        o_req.ctrl  = mem_maint_pkg::FULL_MASK;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// ------------------------------
// testbench clock and reset
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic o_rst_n,
    input  wire  i_rst_req    // pulse to run the reset sequence again
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        o_rst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            #(PERIOD_NS / 8);
            o_rst_n = 1'b1;   // released between edges
            @(posedge i_rst_req);
            o_rst_n = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb_mem_maint.sv */
// ------------------------------
// testbench for the memory maintenance block
// boot, zero fill, image checks, cpu port and a damaged image
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_mem_maint;

    localparam int unsigned IMAGE_WORDS = mem_maint_pkg::IMAGE_BYTES / 4;
    localparam int unsigned ZERO_WORDS  = mem_maint_pkg::ZERO_BYTES / 4;
    localparam int unsigned N_CPU_OPS   = ZERO_WORDS + 5;
    localparam int unsigned BOOT_TXNS   = ZERO_WORDS + 2 * IMAGE_WORDS;
    localparam int unsigned TXN_CYCLES  = 12;   // strobe, accept, 4 busy, settle, loader gap
    localparam int unsigned RST_CYCLES  = 16;
    localparam int unsigned CYCLE_LIMIT =
        (2 * BOOT_TXNS + N_CPU_OPS) * TXN_CYCLES + 4 * RST_CYCLES + 200;
    localparam logic [31:0] LFSR_SEED = 32'h8755_60cc;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam mem_maint_pkg::addr_t DECOY_ADDR = 32'h0000_0800;

    typedef struct packed {
        logic                 wr;
        mem_maint_pkg::addr_t addr;
        mem_maint_pkg::word_t data;
        logic [3:0]           mask;
        mem_maint_pkg::word_t exp_data;
    } cpu_op_t;

    mem_maint_pkg::word_t image_words [IMAGE_WORDS] = '{
        32'h0000_0013, 32'h1234_5678, 32'hffff_fff0, 32'h8000_0001,
        32'hcafe_f00d, 32'h0bad_c0de, 32'h7fff_ffff, 32'h0102_0304,
        32'hfedc_ba98, 32'h5555_aaaa, 32'h0000_0000, 32'hdead_beef,
        32'h1357_9bdf, 32'hf0f0_0f0f, 32'h8000_0000, 32'h2468_ace0
    };
    cpu_op_t cpu_ops [N_CPU_OPS];

    logic                    clk;
    logic                    rst_n;
    logic                    rst_req;
    logic                    calib_done;
    logic                    load_valid;
    logic                    load_take;
    logic                    cpu_busy;
    logic                    mem_busy;
    logic                    boot_done;
    logic                    checksum_match;
    logic                    corrupt;
    logic                    addr_err;
    mem_maint_pkg::word_t    load_data;
    mem_maint_pkg::word_t    cpu_rdata;
    mem_maint_pkg::word_t    mem_rdata;
    mem_maint_pkg::mem_req_t cpu_req;
    mem_maint_pkg::mem_req_t mem_req;
    logic [31:0]             lfsr_q = LFSR_SEED;
    logic [31:0]             lfsr_tmp;
    logic [3:0]              rnd_q = '0;
    logic [3:0]              rnd_tmp;
    int unsigned             cycle_count;

    tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(RST_CYCLES)) u_clock_gen (
        .clk       (clk),
        .o_rst_n   (rst_n),
        .i_rst_req (rst_req)
    );

    mem_maint i_mem_maint (
        .clk              (clk),
        .i_rst_n          (rst_n),
        .i_calib_done     (calib_done),
        .i_load_valid     (load_valid),
        .i_load_data      (load_data),
        .o_load_take      (load_take),
        .i_cpu_req        (cpu_req),
        .o_cpu_rdata      (cpu_rdata),
        .o_cpu_busy       (cpu_busy),
        .o_mem_req        (mem_req),
        .i_mem_busy       (mem_busy),
        .i_mem_rdata      (mem_rdata),
        .o_boot_done      (boot_done),
        .o_checksum_match (checksum_match)
    );

    tb_sdram_model u_sdram_model (
        .clk        (clk),
        .i_rst_n    (rst_n),
        .i_req      (mem_req),
        .i_busy_len (rnd_q[1:0]),
        .i_corrupt  (corrupt),
        .o_busy     (mem_busy),
        .o_rdata    (mem_rdata),
        .o_addr_err (addr_err)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    // four fresh bits per cycle with busy length low and loader gap high
    always @(posedge clk) begin
        lfsr_tmp = lfsr_q;
        for (int k = 0; k < 4; k++) begin
            rnd_tmp[k] = lfsr_tmp[0];
            lfsr_tmp   = lfsr_step(lfsr_tmp);
        end
        lfsr_q <= lfsr_tmp;
        rnd_q  <= rnd_tmp;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_maint_pkg::word_t exp_val,
                              input mem_maint_pkg::word_t act_val);
        if (act_val !== exp_val)
            report_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            report_failure($sformatf("FAIL %s: expected %b, actual %b", name, exp_val, act_val));
    endtask

    function automatic mem_maint_pkg::word_t image_sum();
        mem_maint_pkg::word_t sum;
        sum = '0;
        for (int i = 0; i < IMAGE_WORDS; i++)
            sum = sum + image_words[i];    // wraps modulo 2^32
        return sum;
    endfunction

    // cpu write aimed above the boot regions
    function automatic mem_maint_pkg::mem_req_t decoy_req();
        mem_maint_pkg::mem_req_t r;
        r       = '0;
        r.wr_en = 1'b1;
        r.addr  = DECOY_ADDR;
        r.wdata = 32'hbad0_0bad;
        r.ctrl  = mem_maint_pkg::FULL_MASK;
        return r;
    endfunction

    task automatic set_op(input int idx, input logic wr, input mem_maint_pkg::addr_t addr,
                          input mem_maint_pkg::word_t data, input logic [3:0] mask,
                          input mem_maint_pkg::word_t exp_data);
        cpu_ops[idx] = '{wr, addr, data, mask, exp_data};
    endtask

    task automatic build_cpu_table();
        for (int i = 0; i < ZERO_WORDS; i++) begin
            if (i < IMAGE_WORDS)
                set_op(i, 1'b0, 32'(i * 4), '0, 4'hf, image_words[i]);
            else
                set_op(i, 1'b0, 32'(i * 4), '0, 4'hf, '0);   // zeroed tail
        end
        // byte lanes 0 and 2 replaced while 1 and 3 are kept
        set_op(ZERO_WORDS,     1'b1, 32'h0000_0200, 32'h1122_3344, 4'b1111, '0);
        set_op(ZERO_WORDS + 1, 1'b1, 32'h0000_0200, 32'haabb_ccdd, 4'b0101, '0);
        set_op(ZERO_WORDS + 2, 1'b0, 32'hfc00_0200, '0, 4'b1111, 32'h11bb_33dd);
        set_op(ZERO_WORDS + 3, 1'b1, 32'h0c00_0204, 32'h5a5a_0f0f, 4'b1111, '0);
        set_op(ZERO_WORDS + 4, 1'b0, 32'h0000_0204, '0, 4'b1111, 32'h5a5a_0f0f);
    endtask

    task automatic cpu_access(input int idx);
        cpu_op_t op;
        op = cpu_ops[idx];
        while (cpu_busy) begin
            @(posedge clk);
            #5;
        end
        cpu_req       = '0;
        cpu_req.rd_en = !op.wr;
        cpu_req.wr_en = op.wr;
        cpu_req.addr  = op.addr;
        cpu_req.wdata = op.data;
        cpu_req.ctrl  = op.mask;
        do begin
            @(posedge clk);
            #5;
        end while (!cpu_busy);
        cpu_req.rd_en = 1'b0;
        cpu_req.wr_en = 1'b0;
        while (cpu_busy) begin
            @(posedge clk);
            #5;
        end
        if (!op.wr)
            check_word($sformatf("cpu read %0d at %h", idx, op.addr), op.exp_data, cpu_rdata);
    endtask

    task automatic feed_image();
        int unsigned gap;
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            gap = rnd_q[3:2];
            repeat (gap) begin
                @(posedge clk);
                #5;
            end
            load_valid = 1'b1;
            load_data  = image_words[i];
            do begin
                @(posedge clk);
                #5;
            end while (!load_take);
            load_valid = 1'b0;
        end
    endtask

    // first read strobe of a boot belongs to the verify phase
    task automatic watch_verify(input logic do_corrupt);
        do begin
            @(negedge clk);
        end while (!mem_req.rd_en);
        @(posedge clk);
        #5;
        cpu_req = '0;
        if (do_corrupt) begin
            corrupt = 1'b1;
            @(posedge clk);
            #5;
            corrupt = 1'b0;
        end
    endtask

    task automatic run_boot(input logic exp_match, input logic do_corrupt, input string tag);
        repeat (4) begin
            @(posedge clk);
            #5;
        end
        calib_done = 1'b1;
        fork
            feed_image();
            watch_verify(do_corrupt);
        join
        while (!boot_done) begin
            @(posedge clk);
            #5;
        end
        check_flag({tag, " checksum match"}, exp_match, checksum_match);
        check_word({tag, " copier checksum"}, image_sum(), i_mem_maint.w_checksum);
    endtask

    // boot window rules sampled mid-cycle
    always @(negedge clk) begin
        if (addr_err)
            report_failure("the memory model saw an address outside its range");
        if (!calib_done) begin
            check_flag("boot done before calibration", 1'b0, boot_done);
            if (mem_req.rd_en || mem_req.wr_en)
                report_failure("a memory strobe appeared before calibration");
        end
        if (!boot_done) begin
            check_flag("cpu busy during boot", 1'b1, cpu_busy);
            if ((mem_req.rd_en || mem_req.wr_en) && mem_req.addr >= mem_maint_pkg::ZERO_BYTES)
                report_failure("the cpu request reached the memory port during boot");
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("the run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    initial begin
        rst_req    = 1'b0;
        calib_done = 1'b0;
        load_valid = 1'b0;
        load_data  = '0;
        corrupt    = 1'b0;
        cpu_req    = decoy_req();
        build_cpu_table();
        @(posedge rst_n);
        run_boot(1'b1, 1'b0, "first boot");
        for (int i = 0; i < N_CPU_OPS; i++)
            cpu_access(i);

        // second boot with one image word damaged before it is read back
        rst_req    = 1'b1;
        calib_done = 1'b0;
        @(posedge clk);
        #5;
        rst_req = 1'b0;
        cpu_req = decoy_req();
        @(posedge rst_n);
        run_boot(1'b0, 1'b1, "corrupted boot");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_sdram_model.sv */
// ------------------------------
// behavioral sdram model
// strobe-and-busy protocol, byte masks, random busy length
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_model #(
    parameter int unsigned DEPTH_WORDS  = 1024,
    parameter int unsigned CORRUPT_WORD = 15
) (
    input  wire                          clk,
    input  wire                          i_rst_n,
    input  wire mem_maint_pkg::mem_req_t i_req,
    input  wire [1:0]                    i_busy_len,  // busy cycles minus one
    input  wire                          i_corrupt,
    output logic                         o_busy,
    output mem_maint_pkg::word_t         o_rdata,
    output logic                         o_addr_err
);

    localparam int unsigned IDX_W = $clog2(DEPTH_WORDS);

    mem_maint_pkg::word_t    mem [DEPTH_WORDS];
    mem_maint_pkg::mem_req_t req_q;
    mem_maint_pkg::word_t    merged;
    logic [1:0]              cnt_q;
    logic [IDX_W-1:0]        idx;
    logic                    addr_err_q = 1'b0;  // sticky across resets

    assign idx        = req_q.addr[IDX_W+1:2];
    assign o_addr_err = addr_err_q;

    // nonzero fill that differs per address
    initial begin
        for (int unsigned i = 0; i < DEPTH_WORDS; i++)
            mem[i] = 32'hdead_beef ^ (i << 2);
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy  <= 1'b0;
            cnt_q   <= '0;
            req_q   <= '0;
            o_rdata <= '0;
        end else begin
            if (!o_busy && (i_req.rd_en || i_req.wr_en)) begin
                req_q  <= i_req;
                cnt_q  <= i_busy_len;
                o_busy <= 1'b1;
                if (i_req.addr >= DEPTH_WORDS * 4)
                    addr_err_q <= 1'b1;
            end else if (o_busy) begin
                if (cnt_q != 2'd0) begin
                    cnt_q <= cnt_q - 2'd1;
                end else begin
                    o_busy <= 1'b0;     // access completes here
                    if (req_q.wr_en) begin
                        merged = mem[idx];
                        for (int b = 0; b < 4; b++) begin
                            if (req_q.ctrl[b])
                                merged[8*b +: 8] = req_q.wdata[8*b +: 8];
                        end
                        mem[idx] <= merged;
                    end else begin
                        o_rdata <= mem[idx];
                    end
                end
            end
            if (i_corrupt)
                mem[CORRUPT_WORD] <= mem[CORRUPT_WORD] ^ 32'h0000_0100;  // flip one bit
        end
    end

endmodule

`default_nettype wire

/* zero_fill.sv */
// ------------------------------
// zero fill engine
// writes zero words over the zero region
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module zero_fill (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_start,
    input  wire                     i_mem_busy,
    output mem_maint_pkg::mem_req_t o_req,
    output logic                    o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_BUSY,    // strobe up until the controller answers
        S_WAIT_DONE
    } zf_state_e;

    zf_state_e            state_q;
    mem_maint_pkg::addr_t addr_q;
    mem_maint_pkg::addr_t addr_next;
    logic                 wr_q;

    assign addr_next = mem_maint_pkg::next_word_addr(addr_q);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            addr_q  <= '0;
            wr_q    <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (i_start && !o_done && !i_mem_busy) begin
                        wr_q    <= 1'b1;
                        state_q <= S_WAIT_BUSY;
                    end
                end
                S_WAIT_BUSY: begin
                    if (i_mem_busy) begin
                        wr_q    <= 1'b0;    // controller took it
                        state_q <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: begin
                    if (!i_mem_busy) begin
                        addr_q  <= addr_next;
                        state_q <= S_IDLE;
                        if (addr_next == mem_maint_pkg::addr_t'(mem_maint_pkg::ZERO_BYTES))
                            o_done <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        o_req       = '0;
        o_req.wr_en = wr_q;
        o_req.addr  = addr_q;
        o_req.ctrl  = mem_maint_pkg::FULL_MASK;   // wdata stays zero
    end

    // once the region is covered no further writes go out
    a_no_strobe_when_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_done |-> !o_req.wr_en && !o_req.rd_en);

endmodule

`default_nettype wire
